// ==== Makefile ====
# Verilator build and run of the frequency meter testbench
# a failing run exits through $fatal, so make sees a nonzero status

.PHONY: sim clean

sim:
	verilator --binary --timing -f src.f --top-module freq_counter_tb
	./obj_dir/Vfreq_counter_tb

clean:
	rm -rf obj_dir

// ==== rtl/bin_to_bcd.sv ====
//--------------------------------------------------------------------------
// shift-and-add-3 conversion, one bit per clock, result 11 cycles on
// a new reading while busy restarts the conversion
//--------------------------------------------------------------------------
module bin_to_bcd (
	input  logic                clock,
	input  logic                reset,
	input  freq_pkg::reading_t  reading,
	output freq_pkg::bcd_word_t bcd
);
	import freq_pkg::*;

	// bcd digits on top, binary underneath
	logic [SHIFT_BITS-1:0] work;
	logic [SHIFT_BITS-1:0] work_next;
	// bcd field after the add-3 pass
	logic [BCD_BITS-1:0]   adjusted;

	logic                 busy;
	logic [STEP_BITS-1:0] step;
	logic                 last_step;

	bcd_digits_t digit_q;
	logic        valid_q;

	// one double-dabble step
	always_comb begin
		adjusted = work[SHIFT_BITS-1 -: BCD_BITS];
		for (int i = 0; i < DIGITS; i++) begin
			// nibble of 5 or more would overflow past 9 when doubled
			if (adjusted[i*4 +: 4] >= 4'd5) begin
				adjusted[i*4 +: 4] = adjusted[i*4 +: 4] + 4'd3;
			end
		end
		// msb of the binary moves into the units digit
		work_next = {adjusted, work[READING_BITS-1:0]} << 1;
	end

	assign last_step = busy && (step == STEP_BITS'(READING_BITS - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			busy    <= 1'b0;
			step    <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= last_step;
			if (reading.valid) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				step <= step + STEP_BITS'(1);
				if (last_step) begin
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reading.valid) begin
			// digits start at zero
			work <= {BCD_BITS'(0), reading.value};
		end else if (busy) begin
			work <= work_next;
		end
		// result taken straight from the final step
		if (last_step) begin
			digit_q <= work_next[SHIFT_BITS-1 -: BCD_BITS];
		end
	end

	// digits only change together with valid
	assign bcd = '{digit: digit_q, valid: valid_q};

endmodule

// ==== rtl/digit_scanner.sv ====
//--------------------------------------------------------------------------
// one digit lit at a time, SCAN_CYCLES clocks each, units digit first
// dark until the first bcd word, each new word restarts the scan at digit 0
//--------------------------------------------------------------------------
module digit_scanner (
	input  logic                        clock,
	input  logic                        reset,
	input  freq_pkg::bcd_word_t         bcd,
	output freq_pkg::seg_t              segments,
	output logic [freq_pkg::DIGITS-1:0] anodes
);
	import freq_pkg::*;

	// latest word on the display
	bcd_digits_t shown;
	// set by the first word
	logic started;

	logic [SCAN_BITS-1:0]  scan_count;
	logic                  scan_wrap;
	logic [INDEX_BITS-1:0] index;
	// leading zeros to suppress
	logic [DIGITS-1:0]     blank;

	assign scan_wrap = (scan_count == SCAN_BITS'(SCAN_CYCLES - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			started    <= 1'b0;
			scan_count <= '0;
			index      <= '0;
		end else if (bcd.valid) begin
			started    <= 1'b1;
			scan_count <= '0;
			index      <= '0;
		end else if (started) begin
			if (scan_wrap) begin
				scan_count <= '0;
				// step to the next digit, back to units after the top one
				if (index == INDEX_BITS'(DIGITS - 1)) begin
					index <= '0;
				end else begin
					index <= index + INDEX_BITS'(1);
				end
			end else begin
				scan_count <= scan_count + SCAN_BITS'(1);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (bcd.valid) begin
			shown <= bcd.digit;
		end
	end

	// walk down from the top digit while everything seen is zero
	always_comb begin
		logic leading;
		leading = 1'b1;
		for (int i = DIGITS - 1; i >= 1; i--) begin
			leading  = leading && (shown[i] == 4'd0);
			blank[i] = leading;
		end
		// units always shown, so zero reads as 0
		blank[0] = 1'b0;
	end

	assign anodes   = started ? (DIGITS'(1) << index) : '0;
	assign segments = (started && !blank[index]) ? digit_to_segments(shown[index]) : '0;

endmodule

// ==== rtl/edge_counter.sv ====
//--------------------------------------------------------------------------
// counts rising edges of an asynchronous level, wraps at 2^COUNT_BITS
// input must stay high and low for at least one clock each to be seen
//--------------------------------------------------------------------------
module edge_counter (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  signal_in,
	output freq_pkg::edge_count_t edge_count
);
	import freq_pkg::*;

	// two-flop synchronizer
	logic sync_meta;
	logic sync_stable;
	// previous synchronized level
	logic sync_prev;
	// registered rising-edge strobe
	logic edge_seen;

	always_ff @(posedge clock) begin
		if (reset) begin
			sync_meta   <= 1'b0;
			sync_stable <= 1'b0;
			sync_prev   <= 1'b0;
			edge_seen   <= 1'b0;
			edge_count  <= '0;
		end else begin
			sync_meta   <= signal_in;
			sync_stable <= sync_meta;
			sync_prev   <= sync_stable;
			// low to high on the synchronized level
			edge_seen   <= sync_stable & ~sync_prev;
			// free-running, wraps on its own
			edge_count  <= edge_count + edge_count_t'(edge_seen);
		end
	end

endmodule

// ==== rtl/freq_counter_top.sv ====
//--------------------------------------------------------------------------
// frequency meter, edges of signal_in per gate of GATE_CYCLES clocks
// reading 1 cycle after the gate closes, bcd 11 cycles after the reading
//--------------------------------------------------------------------------
module freq_counter_top (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        signal_in,
	output freq_pkg::reading_t          reading,
	output freq_pkg::bcd_word_t         bcd,
	output freq_pkg::seg_t              segments,
	output logic [freq_pkg::DIGITS-1:0] anodes
);
	import freq_pkg::*;

	// gate closes
	logic        gate_tick;
	// running total of input edges
	edge_count_t edge_count;

	// gate and edge count run side by side
	gate_timer gate_timer_i (
		.clock     (clock),
		.reset     (reset),
		.gate_tick (gate_tick)
	);

	edge_counter edge_counter_i (
		.clock      (clock),
		.reset      (reset),
		.signal_in  (signal_in),
		.edge_count (edge_count)
	);

	// edges per gate
	rate_capture rate_capture_i (
		.clock      (clock),
		.reset      (reset),
		.gate_tick  (gate_tick),
		.edge_count (edge_count),
		.reading    (reading)
	);

	// reading to decimal
	bin_to_bcd bin_to_bcd_i (
		.clock   (clock),
		.reset   (reset),
		.reading (reading),
		.bcd     (bcd)
	);

	// decimal to multiplexed seven-segment
	digit_scanner digit_scanner_i (
		.clock    (clock),
		.reset    (reset),
		.bcd      (bcd),
		.segments (segments),
		.anodes   (anodes)
	);

endmodule

// ==== rtl/freq_pkg.sv ====
//--------------------------------------------------------------------------
// gate length, widths and display timing for the frequency meter
// readings are edges per gate, at most GATE_CYCLES/2 for a synchronized input
//--------------------------------------------------------------------------
package freq_pkg;

	// gate length in clock cycles
	localparam int GATE_CYCLES  = 1000;
	localparam int GATE_BITS    = $clog2(GATE_CYCLES);
	// free-running edge count, wider than any single-gate reading
	localparam int COUNT_BITS   = 16;
	localparam int READING_BITS = 10;
	// display
	localparam int DIGITS       = 4;
	localparam int INDEX_BITS   = $clog2(DIGITS);
	localparam int SCAN_CYCLES  = 16;
	localparam int SCAN_BITS    = $clog2(SCAN_CYCLES);
	// double-dabble working register
	localparam int BCD_BITS     = DIGITS * 4;
	localparam int SHIFT_BITS   = BCD_BITS + READING_BITS;
	localparam int STEP_BITS    = $clog2(READING_BITS);

	typedef logic [COUNT_BITS-1:0] edge_count_t;

	typedef struct packed {
		logic [READING_BITS-1:0] value;
		logic                    valid;
	} reading_t;

	// index 0 is the units digit
	typedef logic [DIGITS-1:0][3:0] bcd_digits_t;

	typedef struct packed {
		bcd_digits_t digit;
		logic        valid;
	} bcd_word_t;

	// bit order g f e d c b a, lit when high
	typedef logic [6:0] seg_t;

	function automatic seg_t digit_to_segments(input logic [3:0] nibble);
		case (nibble)
			4'd0: return 7'h3f;
			4'd1: return 7'h06;
			4'd2: return 7'h5b;
			4'd3: return 7'h4f;
			4'd4: return 7'h66;
			4'd5: return 7'h6d;
			4'd6: return 7'h7d;
			4'd7: return 7'h07;
			4'd8: return 7'h7f;
			4'd9: return 7'h6f;
			// anything outside 0..9 shows as blank
			default: return 7'h00;
		endcase
	endfunction

endpackage

// ==== rtl/gate_timer.sv ====
//--------------------------------------------------------------------------
// gate tick derived from clock, one cycle wide every GATE_CYCLES cycles
// first tick lands GATE_CYCLES cycles after reset is released
//--------------------------------------------------------------------------
module gate_timer (
	input  logic clock,
	input  logic reset,
	output logic gate_tick
);
	import freq_pkg::*;

	logic [GATE_BITS-1:0] gate_count;
	logic                 gate_wrap;

	// last cycle of the gate
	assign gate_wrap = (gate_count == GATE_BITS'(GATE_CYCLES - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			gate_count <= '0;
			gate_tick  <= 1'b0;
		end else begin
			// tick is registered, so it shows one cycle after the wrap
			gate_tick <= gate_wrap;
			if (gate_wrap) begin
				gate_count <= '0;
			end else begin
				gate_count <= gate_count + GATE_BITS'(1);
			end
		end
	end

endmodule

// ==== rtl/rate_capture.sv ====
//--------------------------------------------------------------------------
// edges per gate from a free-running count, modulo the count width
// first reading after reset covers a partial gate
//--------------------------------------------------------------------------
module rate_capture (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  gate_tick,
	input  freq_pkg::edge_count_t edge_count,
	output freq_pkg::reading_t    reading
);
	import freq_pkg::*;

	// count taken at the previous tick
	edge_count_t snapshot;
	// edges since the previous tick
	edge_count_t window_count;

	logic [READING_BITS-1:0] value_q;
	logic                    valid_q;

	// modulo subtraction copes with the count wrapping mid-gate
	assign window_count = edge_count - snapshot;

	always_ff @(posedge clock) begin
		if (reset) begin
			snapshot <= '0;
			valid_q  <= 1'b0;
		end else begin
			valid_q <= gate_tick;
			if (gate_tick) begin
				snapshot <= edge_count;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (gate_tick) begin
			// upper bits are zero for any rate the synchronizer can follow
			value_q <= window_count[READING_BITS-1:0];
		end
	end

	assign reading = '{value: value_q, valid: valid_q};

endmodule

// ==== src.f ====
rtl/freq_pkg.sv
rtl/gate_timer.sv
rtl/edge_counter.sv
rtl/rate_capture.sv
rtl/bin_to_bcd.sv
rtl/digit_scanner.sv
rtl/freq_counter_top.sv
tb/freq_counter_tb.sv

// ==== tb/freq_counter_tb.sv ====
//--------------------------------------------------------------------------
// directed testbench, input periods must divide GATE_CYCLES
// first reading after every rate change covers a mixed gate and is dropped
//--------------------------------------------------------------------------
module freq_counter_tb;
	import freq_pkg::*;

	localparam int CLOCK_PERIOD  = 100;
	localparam int RESET_CYCLES  = 10;
	localparam int BCD_LATENCY   = READING_BITS + 1;
	localparam int SCAN_FRAME    = DIGITS * SCAN_CYCLES;
	localparam int STEADY_PERIOD = 10;
	localparam int RANDOM_RUNS   = 4;
	// run length in gates, with slack for waits between tests
	localparam int TEST_GATES    = 40;
	localparam int MARGIN_CYCLES = 10000;
	localparam int WATCHDOG_TIME = (TEST_GATES * GATE_CYCLES + MARGIN_CYCLES) * CLOCK_PERIOD;

	logic              clock = 1'b0;
	logic              reset;
	logic              signal_in;
	reading_t          reading;
	bcd_word_t         bcd;
	seg_t              segments;
	logic [DIGITS-1:0] anodes;

	// posedge count, read between edges
	int   cycle_count = 0;
	// ends the square wave driver
	logic stim_stop;
	int   seed;
	// divisors of 1000 from 2 up
	int   divisors [15] = '{2, 4, 5, 8, 10, 20, 25, 40, 50, 100, 125, 200, 250, 500, 1000};

	freq_counter_top freq_counter_top_i (
		.clock     (clock),
		.reset     (reset),
		.signal_in (signal_in),
		.reading   (reading),
		.bcd       (bcd),
		.segments  (segments),
		.anodes    (anodes)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	task automatic stop_on_failure(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	// decimal digits by repeated division, units first
	function automatic bcd_digits_t decimal_digits(input int value);
		bcd_digits_t digits;
		int          rest;
		rest = value;
		for (int i = 0; i < DIGITS; i++) begin
			digits[i] = 4'(rest % 10);
			rest = rest / 10;
		end
		return digits;
	endfunction

	// g f e d c b a
	function automatic seg_t segment_pattern(input logic [3:0] nibble);
		case (nibble)
			4'd0: return 7'b0111111;
			4'd1: return 7'b0000110;
			4'd2: return 7'b1011011;
			4'd3: return 7'b1001111;
			4'd4: return 7'b1100110;
			4'd5: return 7'b1101101;
			4'd6: return 7'b1111101;
			4'd7: return 7'b0000111;
			4'd8: return 7'b1111111;
			4'd9: return 7'b1101111;
			default: return 7'b0000000;
		endcase
	endfunction

	// blank when this digit and all above it are zero, units never blank
	function automatic seg_t expected_segments(input bcd_digits_t digits, input int index);
		logic blank;
		blank = (index != 0);
		for (int i = index; i < DIGITS; i++) begin
			if (digits[i] != 4'd0) begin
				blank = 1'b0;
			end
		end
		if (blank) begin
			return 7'b0000000;
		end else begin
			return segment_pattern(digits[index]);
		end
	endfunction

	task automatic check_reading(input reading_t got, input reading_t exp, input string what);
		if (got.valid !== exp.valid || (exp.valid && got.value !== exp.value)) begin
			stop_on_failure($sformatf("[ERROR] %0t: %s reading valid=%0b value=%0d, expected %0b %0d",
				$time, what, got.valid, got.value, exp.valid, exp.value));
		end
	endtask

	task automatic check_bcd(input bcd_word_t got, input bcd_word_t exp, input string what);
		if (got.valid !== exp.valid || (exp.valid && got.digit !== exp.digit)) begin
			stop_on_failure($sformatf("[ERROR] %0t: %s bcd valid=%0b digits=%h, expected %0b %h",
				$time, what, got.valid, got.digit, exp.valid, exp.digit));
		end
	endtask

	task automatic check_display(input seg_t got_seg, input logic [DIGITS-1:0] got_anodes,
			input seg_t exp_seg, input logic [DIGITS-1:0] exp_anodes, input string what);
		if (got_seg !== exp_seg || got_anodes !== exp_anodes) begin
			stop_on_failure($sformatf("[ERROR] %0t: %s segments=%b anodes=%b, expected %b %b",
				$time, what, got_seg, got_anodes, exp_seg, exp_anodes));
		end
	endtask

	// cycle distances between strobes
	task automatic check_timing(input int got, input int exp, input string what);
		if (got != exp) begin
			stop_on_failure($sformatf("[ERROR] %0t: %s took %0d cycles, expected %0d",
				$time, what, got, exp));
		end
	endtask

	// next reading strobe, skips the one already seen
	task automatic wait_reading(output reading_t got, output int at_cycle);
		int waited;
		waited = 0;
		@(negedge clock);
		while (reading.valid !== 1'b1) begin
			if (waited >= GATE_CYCLES + GATE_CYCLES / 2) begin
				stop_on_failure("timed out waiting for a reading from the meter");
			end
			@(negedge clock);
			waited++;
		end
		got = reading;
		at_cycle = cycle_count;
	endtask

	task automatic wait_bcd(output bcd_word_t got, output int at_cycle);
		int waited;
		waited = 0;
		@(negedge clock);
		while (bcd.valid !== 1'b1) begin
			if (waited >= 4 * BCD_LATENCY) begin
				stop_on_failure("timed out waiting for the decimal conversion");
			end
			@(negedge clock);
			waited++;
		end
		got = bcd;
		at_cycle = cycle_count;
	endtask

	// square wave, high for the first half of each period
	task automatic drive_square(input int period);
		int phase;
		phase = 0;
		while (stim_stop !== 1'b1) begin
			@(negedge clock);
			signal_in = (phase < period / 2) ? 1'b1 : 1'b0;
			phase = (phase == period - 1) ? 0 : phase + 1;
		end
		signal_in = 1'b0;
	endtask

	// one full frame of the scan, starting at the units digit
	task automatic check_scan(input bcd_digits_t digits, input string what);
		int index;
		for (int k = 0; k < SCAN_FRAME; k++) begin
			@(negedge clock);
			index = k / SCAN_CYCLES;
			check_display(segments, anodes, expected_segments(digits, index),
				DIGITS'(1) << index, what);
		end
	endtask

	// drop the mixed gate, then check reading, conversion and display
	task automatic check_conversion(input int value, input string what);
		reading_t  got_reading;
		bcd_word_t got_bcd;
		reading_t  exp_reading;
		bcd_word_t exp_bcd;
		int        reading_cycle;
		int        bcd_cycle;
		exp_reading = '{value: READING_BITS'(value), valid: 1'b1};
		exp_bcd = '{digit: decimal_digits(value), valid: 1'b1};
		wait_reading(got_reading, reading_cycle);
		wait_reading(got_reading, reading_cycle);
		check_reading(got_reading, exp_reading, what);
		wait_bcd(got_bcd, bcd_cycle);
		check_timing(bcd_cycle - reading_cycle, BCD_LATENCY, {what, " conversion"});
		check_bcd(got_bcd, exp_bcd, what);
		check_scan(exp_bcd.digit, what);
	endtask

	task automatic measure_rate(input int period, input string what);
		stim_stop = 1'b0;
		fork
			drive_square(period);
			begin
				check_conversion(GATE_CYCLES / period, what);
				stim_stop = 1'b1;
			end
		join
	endtask

	task automatic test_reset_state();
		reading_t  idle_reading;
		bcd_word_t idle_bcd;
		idle_reading = '{value: '0, valid: 1'b0};
		idle_bcd = '{digit: '0, valid: 1'b0};
		reset = 1'b1;
		repeat (RESET_CYCLES) begin
			@(negedge clock);
			check_reading(reading, idle_reading, "in reset");
			check_bcd(bcd, idle_bcd, "in reset");
			check_display(segments, anodes, '0, '0, "in reset");
		end
		reset = 1'b0;
		// nothing moves before the first gate closes
		repeat (GATE_CYCLES - 1) begin
			@(negedge clock);
			check_reading(reading, idle_reading, "first gate");
			check_bcd(bcd, idle_bcd, "first gate");
			check_display(segments, anodes, '0, '0, "first gate");
		end
	endtask

	task automatic test_steady_rate();
		reading_t got;
		reading_t exp;
		int       last_cycle;
		int       this_cycle;
		exp = '{value: READING_BITS'(GATE_CYCLES / STEADY_PERIOD), valid: 1'b1};
		stim_stop = 1'b0;
		fork
			drive_square(STEADY_PERIOD);
			begin
				// partial window from reset
				wait_reading(got, last_cycle);
				wait_reading(got, last_cycle);
				check_reading(got, exp, "steady");
				for (int n = 0; n < 3; n++) begin
					wait_reading(got, this_cycle);
					check_reading(got, exp, "steady");
					check_timing(this_cycle - last_cycle, GATE_CYCLES, "reading spacing");
					last_cycle = this_cycle;
				end
				stim_stop = 1'b1;
			end
		join
	endtask

	task automatic test_conversion();
		measure_rate(2, "period 2");
		measure_rate(4, "period 4");
		measure_rate(8, "period 8");
		measure_rate(40, "period 40");
	endtask

	task automatic test_random_rates();
		int index;
		for (int n = 0; n < RANDOM_RUNS; n++) begin
			index = int'($unsigned($random(seed)) % 15);
			$display("random period %0d", divisors[index]);
			measure_rate(divisors[index], $sformatf("random period %0d", divisors[index]));
		end
	endtask

	// held low, reads 0 with a lone zero on the units digit
	task automatic test_idle_input();
		signal_in = 1'b0;
		check_conversion(0, "idle input");
	endtask

	initial begin
		reset     = 1'b1;
		signal_in = 1'b0;
		stim_stop = 1'b1;
		seed      = 86;
		test_reset_state();
		test_steady_rate();
		test_conversion();
		test_random_rates();
		test_idle_input();
		$display("=== PASS ===");
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		stop_on_failure($sformatf("simulation timed out after %0d time units", WATCHDOG_TIME));
	end

endmodule
